// File: flist.f
+incdir+dv
hdl/rv_exe_pkg.sv
hdl/exe_operand_sel.sv
hdl/exe_alu.sv
hdl/exe_resolve.sv
hdl/exe_top.sv
dv/exe_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute-stage testbench with verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --top-module exe_tb -f flist.f -o exe_tb_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see $build_log"
    exit 1
fi

./obj_dir/exe_tb_sim > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error status, see $sim_log"
    exit 1
fi

if grep -q "Regression failed" "$sim_log"; then
    echo "failure reported, see $sim_log"
    exit 1
fi

if ! grep -q "Regression passed" "$sim_log"; then
    echo "simulation ended without a result, see $sim_log"
    exit 1
fi

echo "no failure reported in $sim_log"
exit 0

// File: dv/exe_model.svh
`ifndef EXE_MODEL_SVH
`define EXE_MODEL_SVH

// expected outputs of one instruction, flags say which are present
typedef struct packed {
    logic      has_wb;
    logic      has_redirect;
    logic      has_mem;
    wb_fwd_t   wb;
    redirect_t redirect;
    mem_req_t  mem;
} expect_t;

// rv32i op and op-imm arithmetic, alt is funct7 bit 5
function automatic logic [DATA_WIDTH-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                   input logic reg_form,
                                                   input logic [DATA_WIDTH-1:0] a,
                                                   input logic [DATA_WIDTH-1:0] b);
    case (f3)
        3'd0:    return (reg_form && alt) ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {{(DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
        3'd3:    return {{(DATA_WIDTH-1){1'b0}}, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? DATA_WIDTH'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [DATA_WIDTH-1:0] a,
                                    input logic [DATA_WIDTH-1:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic expect_t expected_outputs(input dec_instr_t i);
    expect_t e;
    e = '0;
    e.wb.rd_addr = i.rd_addr;
    case (i.opcode)
        OP_R_TYPE: begin
            e.has_wb  = 1'b1;
            e.wb.data = alu_ref(i.funct3, i.funct7[5], 1'b1, i.rs1_data, i.rs2_data);
        end
        OP_I_TYPE: begin
            e.has_wb  = 1'b1;
            e.wb.data = alu_ref(i.funct3, i.funct7[5], 1'b0, i.rs1_data, i.imm);
        end
        OP_LUI: begin
            e.has_wb  = 1'b1;
            e.wb.data = i.imm;
        end
        OP_AUIPC: begin
            e.has_wb  = 1'b1;
            e.wb.data = i.pc + i.imm;
        end
        OP_JAL, OP_JALR: begin
            e.has_wb       = 1'b1;
            e.has_redirect = 1'b1;
            // link value is the next sequential pc
            e.wb.data      = i.pc + 32'd4;
            e.redirect.taken  = 1'b1;
            e.redirect.target = (i.opcode == OP_JAL) ? i.pc + i.imm :
                                (i.rs1_data + i.imm) & ~32'd1;
        end
        OP_BRANCH: begin
            e.has_redirect    = 1'b1;
            e.redirect.taken  = branch_ref(i.funct3, i.rs1_data, i.rs2_data);
            e.redirect.target = i.pc + i.imm;
        end
        OP_LOAD, OP_STORE: begin
            e.has_mem          = 1'b1;
            e.mem.is_store     = (i.opcode == OP_STORE);
            e.mem.funct3       = i.funct3;
            e.mem.addr         = i.rs1_data + i.imm;
            e.mem.store_data   = i.rs2_data;
            e.mem.rd_addr      = i.rd_addr;
        end
        default: begin
            // fence and system retire silently
        end
    endcase
    return e;
endfunction

`endif

// File: dv/exe_tb.sv
`default_nettype none

module exe_tb
    import rv_exe_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int TOTAL_INSTR  = 1200;
    localparam int PIPE_LATENCY = 3;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       pause;
    logic       in_valid;
    logic       in_ready;
    dec_instr_t in_instr;
    logic       wb_valid;
    wb_fwd_t    wb;
    logic       redirect_valid;
    redirect_t  redirect;
    logic       mem_valid;
    logic       mem_ready;
    mem_req_t   mem;

    `include "exe_model.svh"

    expect_t  exp_q[$];
    int       accept_q[$];
    int       cycle = 0;
    int       error_count = 0;
    int       failed_tests = 0;
    int       run_tests = 0;
    logic     in_taken = 1'b0;
    logic     lat_check = 1'b0;
    logic     mem_hold = 1'b0;
    mem_req_t held_mem;

    exe_top exe_top_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .pause          (pause),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_instr       (in_instr),
        .wb_valid       (wb_valid),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .mem_valid      (mem_valid),
        .mem_ready      (mem_ready),
        .mem            (mem)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_wb(input string name, input wb_fwd_t got, input wb_fwd_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got rd=%0d data=%h, expected rd=%0d data=%h",
                     $time, name, got.rd_addr, got.data, exp.rd_addr, exp.data);
            error_count++;
        end
    endtask

    task automatic check_redirect(input string name, input redirect_t got, input redirect_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got taken=%0b target=%h, expected taken=%0b target=%h",
                     $time, name, got.taken, got.target, exp.taken, exp.target);
            error_count++;
        end
    endtask

    task automatic check_mem(input string name, input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // outputs and input handshake, sampled mid-cycle where everything is stable
    always @(negedge clk) begin
        expect_t e;
        int      acc;
        if (rst_n) begin
            if (mem_hold && !mem_valid) begin
                $display("ERROR t=%0t mem_valid dropped before mem_ready was seen", $time);
                error_count++;
            end else if (mem_hold) begin
                check_mem("mem (held)", mem, held_mem);
            end
            if (wb_valid || redirect_valid || (mem_valid && !mem_hold)) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR t=%0t an output appeared with no instruction in flight",
                             $time);
                    error_count++;
                end else begin
                    e   = exp_q.pop_front();
                    acc = accept_q.pop_front();
                    if (e.has_wb != wb_valid || e.has_redirect != redirect_valid ||
                        e.has_mem != (mem_valid && !mem_hold)) begin
                        $display("ERROR t=%0t wrong set of outputs for the oldest instruction",
                                 $time);
                        error_count++;
                    end
                    if (e.has_wb && wb_valid) check_wb("wb", wb, e.wb);
                    if (e.has_redirect && redirect_valid) begin
                        check_redirect("redirect", redirect, e.redirect);
                    end
                    if (e.has_mem && mem_valid) check_mem("mem", mem, e.mem);
                    if (lat_check && (cycle - acc != PIPE_LATENCY)) begin
                        $display("ERROR t=%0t output came %0d cycles after acceptance, not %0d",
                                 $time, cycle - acc, PIPE_LATENCY);
                        error_count++;
                    end
                end
            end
            mem_hold = mem_valid && !mem_ready;
            held_mem = mem;
            in_taken = in_valid && in_ready;
            if (in_taken) begin
                e = expected_outputs(in_instr);
                if (e.has_wb || e.has_redirect || e.has_mem) begin
                    exp_q.push_back(e);
                    accept_q.push_back(cycle);
                end
            end
        end
    end

    function automatic opcode_t opcode_at(input int k);
        case (k)
            0:       return OP_R_TYPE;
            1:       return OP_I_TYPE;
            2:       return OP_LUI;
            3:       return OP_AUIPC;
            4:       return OP_BRANCH;
            5:       return OP_JAL;
            6:       return OP_JALR;
            7:       return OP_LOAD;
            8:       return OP_STORE;
            9:       return OP_FENCE;
            default: return OP_SYSTEM;
        endcase
    endfunction

    // opcode drawn from pool indices lo..hi, fields shaped as a decoder gives them
    function automatic dec_instr_t random_instr(input int lo, input int hi);
        dec_instr_t  i;
        logic [31:0] r;
        logic [31:0] f;
        i        = '0;
        i.opcode = opcode_at(lo + ($urandom % (hi - lo + 1)));
        r        = $urandom;
        i.pc     = {r[31:2], 2'b00};
        i.rs1_data = $urandom;
        r        = $urandom;
        // equal and sign-flipped operands exercise the compares
        case (r[1:0])
            2'd0:    i.rs2_data = i.rs1_data;
            2'd1:    i.rs2_data = {~i.rs1_data[31], i.rs1_data[30:0]};
            default: i.rs2_data = $urandom;
        endcase
        i.rd_addr = r[8:4];
        f         = $urandom;
        i.funct3  = f[7:5];
        r         = $urandom;
        i.imm     = {{20{r[11]}}, r[11:0]};
        case (i.opcode)
            OP_R_TYPE: begin
                if (i.funct3 == 3'd0 || i.funct3 == 3'd5) i.funct7 = f[20] ? 7'h20 : 7'h00;
            end
            OP_I_TYPE: begin
                if (i.funct3 == 3'd1) i.imm = {27'd0, r[4:0]};
                if (i.funct3 == 3'd5) i.imm = {20'd0, f[20] ? 7'h20 : 7'h00, r[4:0]};
                i.funct7 = i.imm[11:5];
            end
            OP_BRANCH: begin
                if (i.funct3[2:1] == 2'b01) i.funct3[1] = 1'b0;
                i.imm = {{19{r[12]}}, r[12:1], 1'b0};
            end
            OP_JAL:   i.imm = {{11{r[20]}}, r[20:1], 1'b0};
            OP_JALR:  i.funct3 = 3'd0;
            OP_LUI, OP_AUIPC: i.imm = {r[31:12], 12'd0};
            OP_LOAD: begin
                if (i.funct3 == 3'd3 || i.funct3 == 3'd6 || i.funct3 == 3'd7) i.funct3 = 3'd2;
            end
            OP_STORE: i.funct3 = (f[6:5] == 2'd3) ? 3'd2 : {1'b0, f[6:5]};
            default:  i.funct7 = f[14:8];
        endcase
        return i;
    endfunction

    task automatic run_stream(input string name, input int count, input int lo, input int hi,
                              input int pause_pct, input int ready_pct, input logic strict);
        int   issued;
        int   errors_before;
        logic done;
        issued        = 0;
        done          = 1'b0;
        errors_before = error_count;
        lat_check     = strict;
        while (!done) begin
            @(posedge clk);
            #1;
            pause     = ($urandom % 100) < pause_pct;
            mem_ready = ($urandom % 100) < ready_pct;
            if (!in_valid || in_taken) begin
                in_valid = 1'b0;
                if (issued == count) begin
                    done = 1'b1;
                end else if (($urandom % 100) < 70) begin
                    in_instr = random_instr(lo, hi);
                    in_valid = 1'b1;
                    issued++;
                end
            end
        end
        // drain the pipeline
        pause     = 1'b0;
        mem_ready = 1'b1;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);
        run_tests++;
        if (error_count != errors_before) failed_tests++;
        $display("test %s: %0d instructions, %0d errors", name, count,
                 error_count - errors_before);
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        if (in_ready !== 1'b1 || wb_valid !== 1'b0 || redirect_valid !== 1'b0 ||
            mem_valid !== 1'b0) begin
            $display("ERROR t=%0t pipeline not idle after reset", $time);
            error_count++;
        end
        run_tests++;
        if (error_count != errors_before) failed_tests++;
        $display("test reset: %0d errors", error_count - errors_before);
    endtask

    initial begin
        void'($urandom(32'h8d6c));
        rst_n     = 1'b0;
        pause     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        mem_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state();
        run_stream("alu_results", 300, 0, 3, 0, 100, 1'b1);
        run_stream("branches", 200, 4, 4, 0, 100, 1'b1);
        run_stream("jumps", 100, 5, 6, 0, 100, 1'b1);
        run_stream("loads_stores", 200, 7, 8, 0, 60, 1'b0);
        run_stream("mixed", 400, 0, 10, 15, 60, 1'b0);
        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 run_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // generous bound of 20 cycles per instruction
    initial begin
        #(20 * TOTAL_INSTR * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("ERROR watchdog expired at cycle %0d, the run did not finish", cycle);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/exe_top.sv
`default_nettype none

module exe_top
    import rv_exe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pause,
    input  logic       in_valid,
    output logic       in_ready,
    input  dec_instr_t in_instr,
    output logic       wb_valid,
    output wb_fwd_t    wb,
    output logic       redirect_valid,
    output redirect_t  redirect,
    output logic       mem_valid,
    input  logic       mem_ready,
    output mem_req_t   mem
);

    // stage 1 to stage 2
    logic     sel_valid;
    logic     sel_ready;
    alu_req_t sel_req;

    // stage 2 to stage 3
    logic     alu_valid;
    logic     alu_ready;
    alu_res_t alu_res;

    exe_operand_sel operand_sel_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pause     (pause),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .sel_valid (sel_valid),
        .sel_ready (sel_ready),
        .sel_req   (sel_req)
    );

    exe_alu alu_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sel_valid (sel_valid),
        .sel_ready (sel_ready),
        .sel_req   (sel_req),
        .alu_valid (alu_valid),
        .alu_ready (alu_ready),
        .alu_res   (alu_res)
    );

    exe_resolve resolve_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_valid      (alu_valid),
        .alu_ready      (alu_ready),
        .alu_res        (alu_res),
        .wb_valid       (wb_valid),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect       (redirect),
        .mem_valid      (mem_valid),
        .mem_ready      (mem_ready),
        .mem            (mem)
    );

endmodule

`default_nettype wire

// File: hdl/exe_resolve.sv
`default_nettype none

module exe_resolve
    import rv_exe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      alu_valid,
    output logic      alu_ready,
    input  alu_res_t  alu_res,
    output logic      wb_valid,
    output wb_fwd_t   wb,
    output logic      redirect_valid,
    output redirect_t redirect,
    output logic      mem_valid,
    input  logic      mem_ready,
    output mem_req_t  mem
);

    logic                  take;
    logic                  wants_wb;
    logic                  wants_redirect;
    logic                  wants_mem;
    logic                  is_jump;
    logic                  br_taken;
    logic                  result_zero;
    logic [ADDR_WIDTH-1:0] link_addr;
    logic [ADDR_WIDTH-1:0] br_target;
    logic [ADDR_WIDTH-1:0] jump_target;

    // only a pending memory request stalls this stage
    assign alu_ready = !mem_valid || mem_ready;
    assign take      = alu_valid && alu_ready;

    assign wants_wb = alu_res.opcode inside {OP_R_TYPE, OP_I_TYPE, OP_LUI, OP_AUIPC,
                                             OP_JAL, OP_JALR};
    assign is_jump        = alu_res.opcode inside {OP_JAL, OP_JALR};
    assign wants_redirect = is_jump || (alu_res.opcode == OP_BRANCH);
    assign wants_mem      = alu_res.opcode inside {OP_LOAD, OP_STORE};

    assign link_addr   = alu_res.pc + ADDR_WIDTH'(4);
    assign br_target   = alu_res.pc + alu_res.imm;
    assign result_zero = (alu_res.result == '0);

    // jalr clears bit 0 of the computed target
    always_comb begin
        jump_target = alu_res.result;
        if (alu_res.opcode == OP_JALR) begin
            jump_target[0] = 1'b0;
        end
    end

    // result is a difference for beq/bne, a 0/1 flag otherwise
    always_comb begin
        case (branch_fn_t'(alu_res.funct3))
            BR_BEQ:           br_taken = result_zero;
            BR_BNE:           br_taken = !result_zero;
            BR_BLT, BR_BLTU:  br_taken = !result_zero;
            BR_BGE, BR_BGEU:  br_taken = result_zero;
            default:          br_taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid       <= 1'b0;
            redirect_valid <= 1'b0;
            mem_valid      <= 1'b0;
        end else begin
            wb_valid       <= take && wants_wb;
            redirect_valid <= take && wants_redirect;
            if (take) begin
                mem_valid <= wants_mem;
            end else if (mem_ready) begin
                mem_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wb.rd_addr <= alu_res.rd_addr;
            wb.data    <= is_jump ? link_addr : alu_res.result;

            redirect.taken  <= is_jump || br_taken;
            redirect.target <= is_jump ? jump_target : br_target;

            mem.is_store   <= (alu_res.opcode == OP_STORE);
            mem.funct3     <= alu_res.funct3;
            mem.addr       <= alu_res.result;
            mem.store_data <= alu_res.rs2_data;
            mem.rd_addr    <= alu_res.rd_addr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exe_alu.sv
`default_nettype none

module exe_alu
    import rv_exe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     sel_valid,
    output logic     sel_ready,
    input  alu_req_t sel_req,
    output logic     alu_valid,
    input  logic     alu_ready,
    output alu_res_t alu_res
);

    logic [DATA_WIDTH-1:0] result;
    logic [4:0]            shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;
    logic                  sel_fire;

    assign shamt       = sel_req.operand2[4:0];
    assign lt_signed   = $signed(sel_req.operand1) < $signed(sel_req.operand2);
    assign lt_unsigned = sel_req.operand1 < sel_req.operand2;

    always_comb begin
        case (sel_req.alu_op)
            ALU_ADD:  result = sel_req.operand1 + sel_req.operand2;
            ALU_SUB:  result = sel_req.operand1 - sel_req.operand2;
            ALU_AND:  result = sel_req.operand1 & sel_req.operand2;
            ALU_OR:   result = sel_req.operand1 | sel_req.operand2;
            ALU_XOR:  result = sel_req.operand1 ^ sel_req.operand2;
            ALU_SLL:  result = sel_req.operand1 << shamt;
            ALU_SRL:  result = sel_req.operand1 >> shamt;
            ALU_SRA:  result = $signed(sel_req.operand1) >>> shamt;
            ALU_SLT:  result = {{(DATA_WIDTH-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
            default:  result = '0;
        endcase
    end

    // take a new item when empty or when stage 3 drains us
    assign sel_ready = !alu_valid || alu_ready;
    assign sel_fire  = sel_valid && sel_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else if (sel_ready) begin
            alu_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_fire) begin
            alu_res.result   <= result;
            alu_res.pc       <= sel_req.pc;
            alu_res.imm      <= sel_req.imm;
            alu_res.opcode   <= sel_req.opcode;
            alu_res.funct3   <= sel_req.funct3;
            alu_res.rs2_data <= sel_req.rs2_data;
            alu_res.rd_addr  <= sel_req.rd_addr;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exe_operand_sel.sv
`default_nettype none

module exe_operand_sel
    import rv_exe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pause,
    input  logic       in_valid,
    output logic       in_ready,
    input  dec_instr_t in_instr,
    output logic       sel_valid,
    input  logic       sel_ready,
    output alu_req_t   sel_req
);

    logic       held_valid;
    dec_instr_t held;
    logic       in_fire;
    logic       sel_fire;

    // item is only offered while not paused
    assign sel_valid = held_valid && !pause;
    assign sel_fire  = sel_valid && sel_ready;
    assign in_ready  = !held_valid || sel_fire;
    assign in_fire   = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
        end else if (in_fire) begin
            held_valid <= 1'b1;
        end else if (sel_fire) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            held <= in_instr;
        end
    end

    always_comb begin
        // context travels unchanged
        sel_req.pc       = held.pc;
        sel_req.imm      = held.imm;
        sel_req.opcode   = held.opcode;
        sel_req.funct3   = held.funct3;
        sel_req.rs2_data = held.rs2_data;
        sel_req.rd_addr  = held.rd_addr;

        sel_req.operand1 = held.rs1_data;
        sel_req.operand2 = held.rs2_data;
        sel_req.alu_op   = ALU_ADD;

        case (held.opcode)
            OP_R_TYPE, OP_I_TYPE: begin
                if (held.opcode == OP_I_TYPE) begin
                    sel_req.operand2 = held.imm;
                end
                case (alu_fn_t'(held.funct3))
                    FN_ADD_SUB: begin
                        // no subtract form for immediates
                        if (held.opcode == OP_R_TYPE && held.funct7[5]) begin
                            sel_req.alu_op = ALU_SUB;
                        end
                    end
                    FN_SLL:     sel_req.alu_op = ALU_SLL;
                    FN_SLT:     sel_req.alu_op = ALU_SLT;
                    FN_SLTU:    sel_req.alu_op = ALU_SLTU;
                    FN_XOR:     sel_req.alu_op = ALU_XOR;
                    FN_SRL_SRA: sel_req.alu_op = held.funct7[5] ? ALU_SRA : ALU_SRL;
                    FN_OR:      sel_req.alu_op = ALU_OR;
                    FN_AND:     sel_req.alu_op = ALU_AND;
                    default:    sel_req.alu_op = ALU_ADD;
                endcase
            end
            OP_BRANCH: begin
                // compare op, stage 3 decides taken
                case (branch_fn_t'(held.funct3))
                    BR_BLT, BR_BGE:   sel_req.alu_op = ALU_SLT;
                    BR_BLTU, BR_BGEU: sel_req.alu_op = ALU_SLTU;
                    default:          sel_req.alu_op = ALU_SUB;
                endcase
            end
            OP_LOAD, OP_STORE, OP_JALR: begin
                sel_req.operand2 = held.imm;
            end
            OP_LUI: begin
                sel_req.operand1 = '0;
                sel_req.operand2 = held.imm;
            end
            OP_AUIPC, OP_JAL: begin
                sel_req.operand1 = held.pc;
                sel_req.operand2 = held.imm;
            end
            default: begin
                // fence and system pass rs1/rs2 through an add
                sel_req.alu_op = ALU_ADD;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rv_exe_pkg.sv
`default_nettype none

package rv_exe_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // rv32i major opcodes, isa encoding
    typedef enum logic [6:0] {
        OP_R_TYPE = 7'b0110011,
        OP_I_TYPE = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_fn_t;

    // funct3 of op and op-imm
    typedef enum logic [2:0] {
        FN_ADD_SUB = 3'b000,
        FN_SLL     = 3'b001,
        FN_SLT     = 3'b010,
        FN_SLTU    = 3'b011,
        FN_XOR     = 3'b100,
        FN_SRL_SRA = 3'b101,
        FN_OR      = 3'b110,
        FN_AND     = 3'b111
    } alu_fn_t;

    // decoded instruction from the decode stage
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]     pc;
        opcode_t                   opcode;
        logic [2:0]                funct3;
        logic [6:0]                funct7;
        logic [DATA_WIDTH-1:0]     rs1_data;
        logic [DATA_WIDTH-1:0]     rs2_data;
        logic [DATA_WIDTH-1:0]     imm;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
    } dec_instr_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     operand1;
        logic [DATA_WIDTH-1:0]     operand2;
        alu_op_t                   alu_op;
        logic [ADDR_WIDTH-1:0]     pc;
        logic [DATA_WIDTH-1:0]     imm;
        opcode_t                   opcode;
        logic [2:0]                funct3;
        logic [DATA_WIDTH-1:0]     rs2_data;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
    } alu_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0]     result;
        logic [ADDR_WIDTH-1:0]     pc;
        logic [DATA_WIDTH-1:0]     imm;
        opcode_t                   opcode;
        logic [2:0]                funct3;
        logic [DATA_WIDTH-1:0]     rs2_data;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
    } alu_res_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic [DATA_WIDTH-1:0]     data;
    } wb_fwd_t;

    typedef struct packed {
        logic                  taken;
        logic [ADDR_WIDTH-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                      is_store;
        logic [2:0]                funct3;
        logic [ADDR_WIDTH-1:0]     addr;
        logic [DATA_WIDTH-1:0]     store_data;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
    } mem_req_t;

endpackage

`default_nettype wire
